// File: hw/mips_isa_pkg.sv
package mips_isa_pkg;

    // Instruction field widths
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] jidx_t;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // Function codes of the SPECIAL opcode, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    localparam reg_idx_t REG_ZERO = 5'd0;

    // Return value register, brought out of the core
    localparam reg_idx_t REG_V0 = 5'd2;

endpackage

// File: hw/mips_core_pkg.sv
package mips_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } cpu_state_t;

    // A fetch from here stops the core
    localparam addr_t HALT_ADDR = 32'h0000_0000;

endpackage

// File: hw/mips_regfile.sv
`timescale 1ns/100ps

module mips_regfile
    import mips_isa_pkg::*, mips_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    register_v0
);

    word_t regs [32];

    assign rs_data     = regs[rs_idx];
    assign rt_data     = regs[rt_idx];
    assign register_v0 = regs[REG_V0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != REG_ZERO) begin
            // Register zero is never written and stays zero from reset
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: hw/mips_execute.sv
`timescale 1ns/100ps

module mips_execute
    import mips_isa_pkg::*, mips_core_pkg::*;
(
    input  instr_t   instr,
    input  addr_t    pc,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output word_t    alu_result,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output mem_op_t  mem_op,
    output addr_t    mem_addr,
    output logic     branch_taken,
    output addr_t    branch_target
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rd_idx;
    shamt_t   shamt;
    imm_t     imm;
    jidx_t    jidx;
    word_t    imm_sext;
    addr_t    pc_next;
    addr_t    addr_sum;

    assign opcode = opcode_t'(instr[31:26]);
    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];
    assign rd_idx = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = funct_t'(instr[5:0]);
    assign imm    = instr[15:0];
    assign jidx   = instr[25:0];

    assign imm_sext = {{16{imm[15]}}, imm};
    assign pc_next  = pc + 32'd4;

    // Word accesses only, low bits dropped
    assign addr_sum = rs_data + imm_sext;
    assign mem_addr = {addr_sum[31:2], 2'b00};

    always_comb begin
        alu_result    = '0;
        wb_en         = 1'b0;
        wb_reg        = rt_idx;
        mem_op        = MEM_NONE;
        branch_taken  = 1'b0;
        branch_target = pc_next + {imm_sext[29:0], 2'b00};
        case (opcode)
            OP_SPECIAL: begin
                wb_reg = rd_idx;
                wb_en  = 1'b1;
                case (funct)
                    FN_ADDU: alu_result = rs_data + rt_data;
                    FN_SUBU: alu_result = rs_data - rt_data;
                    FN_AND:  alu_result = rs_data & rt_data;
                    FN_OR:   alu_result = rs_data | rt_data;
                    FN_XOR:  alu_result = rs_data ^ rt_data;
                    FN_SLT:  alu_result = {31'b0, $signed(rs_data) < $signed(rt_data)};
                    FN_SLTU: alu_result = {31'b0, rs_data < rt_data};
                    FN_SLL:  alu_result = rt_data << shamt;
                    FN_SRL:  alu_result = rt_data >> shamt;
                    FN_JR: begin
                        wb_en         = 1'b0;
                        branch_taken  = 1'b1;
                        branch_target = rs_data;
                    end
                    default: wb_en = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_result = rs_data + imm_sext;
                wb_en      = 1'b1;
            end
            OP_ORI: begin
                alu_result = rs_data | {16'h0000, imm};
                wb_en      = 1'b1;
            end
            OP_LUI: begin
                alu_result = {imm, 16'h0000};
                wb_en      = 1'b1;
            end
            OP_LW:  mem_op = MEM_LOAD;
            OP_SW:  mem_op = MEM_STORE;
            OP_BEQ: branch_taken = (rs_data == rt_data);
            OP_BNE: branch_taken = (rs_data != rt_data);
            OP_J: begin
                branch_taken  = 1'b1;
                branch_target = {pc_next[31:28], jidx, 2'b00};
            end
            default: wb_en = 1'b0;
        endcase
    end

endmodule

// File: hw/mips_control.sv
`timescale 1ns/100ps

module mips_control
    import mips_isa_pkg::*, mips_core_pkg::*;
#(
    parameter addr_t RESET_VECTOR = 32'hbfc0_0000
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     waitrequest,
    input  word_t    readdata,
    input  word_t    alu_result,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  mem_op_t  mem_op,
    input  addr_t    mem_addr,
    input  logic     branch_taken,
    input  addr_t    branch_target,
    input  word_t    rt_data,
    output logic     active,
    output addr_t    address,
    output logic     read,
    output logic     write,
    output word_t    writedata,
    output byte_en_t byteenable,
    output instr_t   instr,
    output addr_t    pc,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data
);

    cpu_state_t state;
    instr_t     ir;
    logic       stall;
    logic       jump_pending;
    addr_t      jump_target;
    logic       exec_hold;
    logic       halt_fetch;

    // Fresh instruction straight off the bus, held copy once stalled
    assign instr = (state == EXEC && !stall) ? readdata : ir;

    // Memory access in EXEC not yet accepted
    assign exec_hold = (state == EXEC) && (mem_op != MEM_NONE) && waitrequest;

    assign halt_fetch = (pc == HALT_ADDR);

    assign active = (state != HALTED);

    always_comb begin
        read    = 1'b0;
        write   = 1'b0;
        address = pc;
        case (state)
            FETCH: begin
                read = !halt_fetch;
            end
            EXEC: begin
                if (mem_op == MEM_LOAD) begin
                    read    = 1'b1;
                    address = mem_addr;
                end else if (mem_op == MEM_STORE) begin
                    write   = 1'b1;
                    address = mem_addr;
                end
            end
            default: begin
                read  = 1'b0;
                write = 1'b0;
            end
        endcase
    end

    assign writedata  = rt_data;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    // One write port shared by ALU results and load data
    assign wr_en   = (state == EXEC && wb_en && !exec_hold) || (state == MEM_ACCESS);
    assign wr_idx  = wb_reg;
    assign wr_data = (state == MEM_ACCESS) ? readdata : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= FETCH;
            pc           <= RESET_VECTOR;
            stall        <= 1'b0;
            jump_pending <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (halt_fetch) begin
                        state <= HALTED;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    stall <= exec_hold;
                    if (!exec_hold) begin
                        state <= (mem_op == MEM_LOAD) ? MEM_ACCESS : FETCH;
                        // Delay slot done, so the recorded target takes over
                        pc <= jump_pending ? jump_target : pc + 32'd4;
                        jump_pending <= branch_taken;
                    end
                end
                MEM_ACCESS: begin
                    state <= FETCH;
                end
                default: begin
                    state <= HALTED;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            ir <= instr;
            if (!exec_hold && branch_taken) begin
                jump_target <= branch_target;
            end
        end
    end

endmodule

// File: hw/mips_cpu_bus.sv
`timescale 1ns/100ps

module mips_cpu_bus
    import mips_isa_pkg::*, mips_core_pkg::*;
#(
    parameter addr_t RESET_VECTOR = 32'hbfc0_0000
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     waitrequest,
    input  word_t    readdata,
    output logic     active,
    output word_t    register_v0,
    output addr_t    address,
    output logic     read,
    output logic     write,
    output word_t    writedata,
    output byte_en_t byteenable
);

    instr_t   instr;
    addr_t    pc;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_result;
    logic     wb_en;
    reg_idx_t wb_reg;
    mem_op_t  mem_op;
    addr_t    mem_addr;
    logic     branch_taken;
    addr_t    branch_target;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    mips_control #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_control (
        .clk           (clk),
        .reset         (reset),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .alu_result    (alu_result),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .mem_op        (mem_op),
        .mem_addr      (mem_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .rt_data       (rt_data),
        .active        (active),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .instr         (instr),
        .pc            (pc),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data)
    );

    mips_execute u_execute (
        .instr         (instr),
        .pc            (pc),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .alu_result    (alu_result),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .mem_op        (mem_op),
        .mem_addr      (mem_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    mips_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

endmodule

// File: test/mips_cpu_bus_assert.sv
`timescale 1ns/100ps

module mips_cpu_bus_assert
    import mips_isa_pkg::*, mips_core_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     waitrequest,
    input logic     read,
    input logic     write,
    input addr_t    address,
    input word_t    writedata,
    input byte_en_t byteenable,
    input instr_t   instr,
    input word_t    rt_data
);

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write are high together");

    // A stalled access keeps every bus output until it is accepted
    held_while_waiting: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) &&
            $stable(writedata) && $stable(byteenable))
        else $error("bus outputs changed during waitrequest");

    word_access: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> (address[1:0] == 2'b00))
        else $error("access address is not word-aligned");

    // Register zero seen through the rt read port
    zero_register: assert property (@(posedge clk) disable iff (reset)
        (instr[20:16] == REG_ZERO) |-> (rt_data == '0))
        else $error("register zero reads nonzero");

endmodule

bind mips_control mips_cpu_bus_assert u_bus_assert (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .read        (read),
    .write       (write),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .instr       (instr),
    .rt_data     (rt_data)
);

// File: test/mips_cpu_bus_tb.sv
`timescale 1ns/100ps

module mips_cpu_bus_tb
    import mips_isa_pkg::*, mips_core_pkg::*;
();

    localparam addr_t RESET_VECTOR = 32'hbfc0_0000;
    localparam int    HALT_IDLE    = 5;

    logic     clk;
    logic     reset;
    logic     waitrequest = 1'b0;
    word_t    readdata = '0;
    logic     active;
    word_t    register_v0;
    addr_t    address;
    logic     read;
    logic     write;
    word_t    writedata;
    byte_en_t byteenable;

    word_t      cases [256];
    word_t      mem [logic [29:0]];
    logic [7:0] case_pos = 8'd0;
    integer     seed = 74;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         access_count = 0;
    word_t      read_word = '0;
    logic       first_read_seen = 1'b0;
    addr_t      first_read_addr;
    logic       first_read_write;
    logic       first_read_active;

    mips_cpu_bus #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_mips_cpu_bus (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Words never written read back a pattern of their own address
    function automatic word_t mem_word(addr_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return ~addr ^ 32'h5a5a_a5a5;
    endfunction

    task automatic load_program();
        word_t      count;
        addr_t      load_addr;
        logic [7:0] pos;
        mem.delete();
        count     = cases[case_pos];
        load_addr = RESET_VECTOR;
        pos       = case_pos + 8'd4;
        repeat (count) begin
            mem[load_addr[31:2]] = cases[pos];
            load_addr = load_addr + 32'd4;
            pos       = pos + 8'd1;
        end
    endtask

    task automatic fail_run(string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_byte_en(string name, byte_en_t got, byte_en_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // The memory model reloads the program while reset is high
    always @(posedge clk) begin
        if (reset) begin
            load_program();
            first_read_seen = 1'b0;
        end else if (!waitrequest && (read || write)) begin
            access_count++;
            check_byte_en("byteenable", byteenable, 4'b1111);
            if (read) begin
                read_word = mem_word(address);
                if (!first_read_seen) begin
                    first_read_seen   = 1'b1;
                    first_read_addr   = address;
                    first_read_write  = write;
                    first_read_active = active;
                end
            end else begin
                mem[address[31:2]] = writedata;
            end
        end
    end

    // About one access cycle in three is stalled
    always @(negedge clk) begin
        int rnd;
        rnd = $random(seed);
        waitrequest <= ((rnd & 32'h7fff_ffff) % 3) == 0;
        readdata    <= read_word;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the core did not halt", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    task automatic run_case();
        word_t v0_at_halt;
        int    accesses_at_halt;
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        while (active) begin
            @(negedge clk);
        end
        v0_at_halt       = register_v0;
        accesses_at_halt = access_count;
        repeat (HALT_IDLE) @(negedge clk);
        check_flag("first read accepted", first_read_seen, 1'b1);
        check_addr("address of first read", first_read_addr, RESET_VECTOR);
        check_flag("write at first read", first_read_write, 1'b0);
        check_flag("active at first read", first_read_active, 1'b1);
        check_word("register_v0", register_v0, cases[case_pos + 8'd1]);
        check_word("register_v0 after halt", register_v0, v0_at_halt);
        check_flag("active after halt", active, 1'b0);
        check_flag("access after halt", access_count != accesses_at_halt, 1'b0);
        if (cases[case_pos + 8'd2] != 32'd0) begin
            check_word("memory word", mem_word(cases[case_pos + 8'd2]), cases[case_pos + 8'd3]);
        end
    endtask

    initial begin
        logic [7:0] pos;
        int         total_words;
        reset = 1'b1;
        $readmemh("test/mips_cases.mem", cases);
        pos         = 8'd0;
        total_words = 0;
        while (cases[pos] != 32'd0) begin
            total_words += cases[pos];
            pos = pos + 8'd4 + cases[pos][7:0];
        end
        cycle_limit = 100 + 8 * total_words;
        case_pos = 8'd0;
        while (cases[case_pos] != 32'd0) begin
            run_case();
            case_pos = case_pos + 8'd4 + cases[case_pos][7:0];
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: mips_lite.f
hw/mips_isa_pkg.sv
hw/mips_core_pkg.sv
hw/mips_regfile.sv
hw/mips_execute.sv
hw/mips_control.sv
hw/mips_cpu_bus.sv
test/mips_cpu_bus_assert.sv
test/mips_cpu_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mips_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module mips_cpu_bus_tb \
    -Mdir obj_dir -f mips_lite.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmips_cpu_bus_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// File: test/mips_cases.mem
// Record: word count, expected register_v0, memory address (0 for none), memory word
// then the program words from the reset vector; a zero count ends the list
// ALU and immediate forms, write to register zero
00000013 00123538 00000000 00000000
3c081234 35085678 2409fffd 01095021 01095823
014b6024 014b6825 018d7026 0120782a 0009c02b
000ec900 00081a02 24000005 00791021 004f1021
00581021 00401021 00000008 00000000
// Store then load back through register 2
00000007 cafef00d 00001008 cafef00d
3c08cafe 3508f00d 24091010 ad28fff8
8d22fff8 00000008 00000000
// Taken BEQ, not taken BNE, JR to zero with delay slots
0000000b 00001611 00000000 00000000
24020001 24080007 11080002 24420010
24420100 15080001 24420200 24420400
00000008 24421000 24422000
00000000
